// File: design/mmu_consts.svh
/*
 * Size and timing constants for the systolic matrix multiplier.
 * Included by the package and by every module that sizes logic from them.
 */

`ifndef MMU_CONSTS_SVH
`define MMU_CONSTS_SVH

// Grid side length, rows and columns of cells
`define MMU_N 4

// Signed operand width for A and B elements
`define MMU_DATA_W 16

// Accumulator width, 32-bit product plus growth over N terms
`define MMU_ACC_W 36

// First input beat to done pulse, in cycles
`define MMU_LATENCY (3 * `MMU_N - 1)

`endif

// File: design/mmu_pkg.sv
/*
 * Shared types of the matrix multiplier.
 * Modules name these types in their ports and import the package in their bodies.
 */
`default_nettype none

`include "mmu_consts.svh"

package mmu_pkg;

    // Scalar widths
    typedef logic signed [`MMU_DATA_W-1:0] data_t;
    typedef logic signed [`MMU_ACC_W-1:0]  acc_t;

    // One operand per row or column lane
    typedef data_t [`MMU_N-1:0] lane_vec_t;

    // Beat k carries column k of A and row k of B
    typedef struct packed {
        lane_vec_t a_col;
        lane_vec_t b_row;
    } beat_t;

    // Full product, indexed [row][col]
    typedef acc_t [`MMU_N-1:0][`MMU_N-1:0] result_mat_t;

    // Job sequencer FSM states
    typedef enum logic {idle, run} job_state_t;

endpackage

`default_nettype wire

// File: design/mac_pe.sv
/*
 * One multiply-accumulate cell of the output-stationary grid.
 * Operands move one cell east or south per cycle; the sum stays in place.
 */
`timescale 1ns/1ps
`default_nettype none

`include "mmu_consts.svh"

module mac_pe (
    input  logic          clk,
    input  logic          rst,
    input  logic          clear,
    input  mmu_pkg::data_t west_in,
    input  mmu_pkg::data_t north_in,
    output mmu_pkg::data_t east_out,
    output mmu_pkg::data_t south_out,
    output mmu_pkg::acc_t  acc
);

    import mmu_pkg::*;

    // Full-width signed product of the current operand pair
    logic signed [2*`MMU_DATA_W-1:0] prod;

    assign prod = west_in * north_in;

    ////////////////////////////////////////
    // Operand forwarding and accumulation
    ////////////////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            east_out  <= '0;
            south_out <= '0;
            acc       <= '0;
        end else begin
            // One cycle hop to the neighbours
            east_out  <= west_in;
            south_out <= north_in;
            // Clear starts a new sum from this product
            if (clear) begin
                acc <= acc_t'(prod);
            end else begin
                acc <= acc + acc_t'(prod);
            end
        end
    end

endmodule

`default_nettype wire

// File: design/skew_feeder.sv
/*
 * Input stage of the multiplier.
 * Registers each beat and delays lane i by i more cycles, so that the grid
 * receives the diagonal wavefront without any skew from the caller.
 */
`timescale 1ns/1ps
`default_nettype none

`include "mmu_consts.svh"

module skew_feeder (
    input  logic               clk,
    input  logic               rst,
    input  logic               in_valid,
    input  mmu_pkg::beat_t     in_beat,
    output mmu_pkg::lane_vec_t west_lanes,
    output mmu_pkg::lane_vec_t north_lanes
);

    import mmu_pkg::*;

    // Captured beat, zero between jobs
    beat_t beat_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            beat_q <= '0;
        end else begin
            beat_q <= in_valid ? in_beat : '0;
        end
    end

    ////////////////////////////////////////
    // Per-lane skew chains
    ////////////////////////////////////////

    for (genvar i = 0; i < `MMU_N; i++) begin : g_lane
        if (i == 0) begin : g_direct
            // Lane 0 needs only the capture register
            assign west_lanes[i]  = beat_q.a_col[i];
            assign north_lanes[i] = beat_q.b_row[i];
        end else begin : g_delay
            // i extra stages for A row lane and B column lane
            data_t a_dly [i];
            data_t b_dly [i];

            always_ff @(posedge clk or posedge rst) begin
                if (rst) begin
                    for (int d = 0; d < i; d++) begin
                        a_dly[d] <= '0;
                        b_dly[d] <= '0;
                    end
                end else begin
                    a_dly[0] <= beat_q.a_col[i];
                    b_dly[0] <= beat_q.b_row[i];
                    for (int d = 1; d < i; d++) begin
                        a_dly[d] <= a_dly[d-1];
                        b_dly[d] <= b_dly[d-1];
                    end
                end
            end

            assign west_lanes[i]  = a_dly[i-1];
            assign north_lanes[i] = b_dly[i-1];
        end
    end

endmodule

`default_nettype wire

// File: design/systolic_grid.sv
/*
 * N by N mesh of MAC cells.
 * Row operands enter on the west edge, column operands on the north edge,
 * and every cell's sum is presented in parallel as the result matrix.
 */
`timescale 1ns/1ps
`default_nettype none

`include "mmu_consts.svh"

module systolic_grid (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 clear,
    input  mmu_pkg::lane_vec_t   west_lanes,
    input  mmu_pkg::lane_vec_t   north_lanes,
    output mmu_pkg::result_mat_t result
);

    import mmu_pkg::*;

    // Horizontal links, column N is the unused east edge
    data_t h_bus [`MMU_N][`MMU_N+1];
    // Vertical links, row N is the unused south edge
    data_t v_bus [`MMU_N+1][`MMU_N];

    ////////////////////////////////////////
    // Edge feeds
    ////////////////////////////////////////

    for (genvar e = 0; e < `MMU_N; e++) begin : g_edge
        assign h_bus[e][0] = west_lanes[e];
        assign v_bus[0][e] = north_lanes[e];
    end

    ////////////////////////////////////////
    // Cell array
    ////////////////////////////////////////

    for (genvar i = 0; i < `MMU_N; i++) begin : g_row
        for (genvar j = 0; j < `MMU_N; j++) begin : g_col
            mac_pe u_pe (
                .clk       (clk),
                .rst       (rst),
                .clear     (clear),
                .west_in   (h_bus[i][j]),
                .north_in  (v_bus[i][j]),
                .east_out  (h_bus[i][j+1]),
                .south_out (v_bus[i+1][j]),
                .acc       (result[i][j])
            );
        end
    end

endmodule

`default_nettype wire

// File: design/job_sequencer.sv
/*
 * Job control for the multiplier.
 * Starts on the first valid beat, clears the sums one cycle later and
 * pulses done a fixed latency after the start. A new job may start on done.
 */
`timescale 1ns/1ps
`default_nettype none

`include "mmu_consts.svh"

module job_sequencer (
    input  logic clk,
    input  logic rst,
    input  logic in_valid,
    output logic clear,
    output logic busy,
    output logic done
);

    import mmu_pkg::*;

    // Holds up to MMU_LATENCY-1
    localparam int CNT_W = $clog2(`MMU_LATENCY);

    job_state_t       state;
    logic [CNT_W-1:0] cnt;
    logic             start;

    // First beat when idle, or a new job in the done cycle
    assign start = in_valid && (state == idle || cnt == '0);

    ////////////////////////////////////////
    // FSM and latency counter
    ////////////////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= idle;
            cnt   <= '0;
            clear <= 1'b0;
        end else begin
            clear <= start;
            if (start) begin
                state <= run;
                cnt   <= CNT_W'(`MMU_LATENCY - 1);
            end else if (state == run) begin
                // Count reaches zero in the done cycle
                if (cnt == '0) begin
                    state <= idle;
                end else begin
                    cnt <= cnt - 1'b1;
                end
            end
        end
    end

    // Done is the last run cycle, busy covers the ones before it
    assign done = (state == run) && (cnt == '0);
    assign busy = (state == run) && (cnt != '0);

endmodule

`default_nettype wire

// File: design/mmu_top.sv
/*
 * Top level of the systolic matrix multiplier.
 * Drive N consecutive valid beats per job, then read result on done.
 */
`timescale 1ns/1ps
`default_nettype none

module mmu_top (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 in_valid,
    input  mmu_pkg::beat_t       in_beat,
    output mmu_pkg::result_mat_t result,
    output logic                 busy,
    output logic                 done
);

    import mmu_pkg::*;

    // Skewed operand lanes into the grid
    lane_vec_t west_lanes;
    lane_vec_t north_lanes;
    // Accumulator restart for a new job
    logic      clear;

    skew_feeder u_feeder (
        .clk         (clk),
        .rst         (rst),
        .in_valid    (in_valid),
        .in_beat     (in_beat),
        .west_lanes  (west_lanes),
        .north_lanes (north_lanes)
    );

    systolic_grid u_grid (
        .clk         (clk),
        .rst         (rst),
        .clear       (clear),
        .west_lanes  (west_lanes),
        .north_lanes (north_lanes),
        .result      (result)
    );

    job_sequencer u_seq (
        .clk      (clk),
        .rst      (rst),
        .in_valid (in_valid),
        .clear    (clear),
        .busy     (busy),
        .done     (done)
    );

endmodule

`default_nettype wire

// File: tests/mmu_clk_gen.sv
/*
 * Testbench clock and power-on reset for the matrix multiplier.
 * Reset is held high over the first RST_CYCLES rising edges.
 */
`timescale 1ns/1ps
`default_nettype none

module mmu_clk_gen #(
    parameter int PERIOD     = 20,
    parameter int RST_CYCLES = 3
) (
    output logic clk,
    output logic rst
);

    // Free-running clock, starts low
    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // Release lands just after an edge, like the other inputs
    initial begin
        rst = 1'b1;
        repeat (RST_CYCLES) @(posedge clk);
        #2;
        rst = 1'b0;
    end

endmodule

`default_nettype wire

// File: tests/mmu_chk.sv
/*
 * Timing assertions for the job sequencer.
 * Bound into job_sequencer by the testbench; fail_count is read at end of run.
 */
`timescale 1ns/1ps
`default_nettype none

`include "mmu_consts.svh"

module mmu_chk (
    input logic                clk,
    input logic                rst,
    input logic                in_valid,
    input logic                clear,
    input logic                busy,
    input logic                done,
    input mmu_pkg::job_state_t state
);

    import mmu_pkg::*;

    // Failed assertions so far
    int   fail_count = 0;
    // Job start as the interface defines it
    logic start;

    assign start = in_valid && (state == idle || done);

    ////////////////////////////////////////
    // Sequencer timing rules
    ////////////////////////////////////////

    // Clear is a single pulse right after the start
    a_clear_pulse: assert property (@(posedge clk) disable iff (rst)
        start |=> clear ##1 !clear)
    else begin
        $error("clear is not a single pulse one cycle after job start");
        fail_count++;
    end

    // Fixed job latency to done
    a_done_latency: assert property (@(posedge clk) disable iff (rst)
        start |-> ##(`MMU_LATENCY) done)
    else begin
        $error("done did not follow job start by the fixed latency");
        fail_count++;
    end

    // Done only closes a busy job started one latency earlier
    a_done_in_job: assert property (@(posedge clk) disable iff (rst)
        done |-> $past(start, `MMU_LATENCY) && $past(busy))
    else begin
        $error("done high outside a job started the fixed latency earlier");
        fail_count++;
    end

endmodule

`default_nettype wire

// File: tests/mmu_tb.sv
/*
 * Random-stimulus testbench for the systolic matrix multiplier.
 * Runs random, extreme, back-to-back and gapped jobs against a matrix model.
 */
`timescale 1ns/1ps
`default_nettype none

`include "mmu_consts.svh"

module mmu_tb;

    import mmu_pkg::*;

    localparam int N               = `MMU_N;
    localparam int L               = `MMU_LATENCY;
    localparam int NUM_JOBS        = 12;
    localparam int WATCHDOG_CYCLES = NUM_JOBS * (L + N) + 50;
    localparam data_t DATA_MIN     = {1'b1, {(`MMU_DATA_W-1){1'b0}}};
    localparam data_t DATA_MAX     = {1'b0, {(`MMU_DATA_W-1){1'b1}}};

    logic        clk;
    logic        rst;
    logic        in_valid;
    beat_t       in_beat;
    result_mat_t result;
    logic        busy;
    logic        done;

    // Current job operands and model sums
    data_t       a_mat [N][N];
    data_t       b_mat [N][N];
    result_mat_t exp_res;
    // Sums the DUT must hold until the next clear
    result_mat_t prev_res;
    logic [31:0] lcg_state = 32'h4a9e_1009;

    mmu_clk_gen #(.PERIOD(20), .RST_CYCLES(3)) i_clk_gen (.clk(clk), .rst(rst));

    mmu_top i_dut (
        .clk      (clk),
        .rst      (rst),
        .in_valid (in_valid),
        .in_beat  (in_beat),
        .result   (result),
        .busy     (busy),
        .done     (done)
    );

    bind job_sequencer mmu_chk i_chk (
        .clk      (clk),
        .rst      (rst),
        .in_valid (in_valid),
        .clear    (clear),
        .busy     (busy),
        .done     (done),
        .state    (state)
    );

    ////////////////////////////////////////
    // Stimulus and model
    ////////////////////////////////////////

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Mode 0 random, 1 mixed extremes, 2 all minimum, 3 max times min
    function automatic data_t pick_operand(input int mode, input logic is_b);
        logic [31:0] r;
        r = next_rand();
        case (mode)
            1: return r[31] ? DATA_MAX : DATA_MIN;
            2: return DATA_MIN;
            3: return is_b ? DATA_MIN : DATA_MAX;
            default: return data_t'(r[31:16]);
        endcase
    endfunction

    task automatic fill_matrices(input int mode);
        for (int i = 0; i < N; i++) begin
            for (int k = 0; k < N; k++) begin
                a_mat[i][k] = pick_operand(mode, 1'b0);
                b_mat[i][k] = pick_operand(mode, 1'b1);
            end
        end
    endtask

    // C[i][j] = sum over k of A[i][k] * B[k][j], in accumulator width
    function automatic result_mat_t model_product();
        result_mat_t m;
        for (int i = 0; i < N; i++) begin
            for (int j = 0; j < N; j++) begin
                m[i][j] = '0;
                for (int k = 0; k < N; k++) begin
                    m[i][j] += acc_t'(a_mat[i][k]) * acc_t'(b_mat[k][j]);
                end
            end
        end
        return m;
    endfunction

    // Beat k: column k of A and row k of B
    function automatic beat_t make_beat(input int k);
        beat_t b;
        for (int i = 0; i < N; i++) begin
            b.a_col[i] = a_mat[i][k];
            b.b_row[i] = b_mat[k][i];
        end
        return b;
    endfunction

    // Junk on the bus while in_valid is low
    function automatic beat_t random_beat();
        beat_t b;
        for (int i = 0; i < N; i++) begin
            b.a_col[i] = data_t'(next_rand());
            b.b_row[i] = data_t'(next_rand());
        end
        return b;
    endfunction

    ////////////////////////////////////////
    // Compare tasks
    ////////////////////////////////////////

    task automatic check_result(input string name, input acc_t got, input acc_t exp);
        if (got !== exp) begin
            $display("mismatch %s got %h expected %h", name, got, exp);
            $display("SOME TESTS FAILED");
            $fatal(1);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("mismatch %s got %h expected %h", name, got, exp);
            $display("SOME TESTS FAILED");
            $fatal(1);
        end
    endtask

    task automatic check_matrix(input result_mat_t exp);
        for (int i = 0; i < N; i++) begin
            for (int j = 0; j < N; j++) begin
                check_result($sformatf("result[%0d][%0d]", i, j), result[i][j], exp[i][j]);
            end
        end
    endtask

    ////////////////////////////////////////
    // Cycle tasks, entered 1 ns after an edge
    ////////////////////////////////////////

    task automatic idle_cycle();
        #1;
        in_valid = 1'b0;
        in_beat  = random_beat();
        @(posedge clk);
        #1;
        check_flag("done", done, 1'b0);
        check_flag("busy", busy, 1'b0);
        check_matrix(prev_res);
    endtask

    // Drives N beats from this cycle on, returns in the done cycle
    task automatic run_job(input int mode);
        fill_matrices(mode);
        exp_res = model_product();
        #1;
        in_valid = 1'b1;
        in_beat  = make_beat(0);
        for (int cyc = 1; cyc <= L; cyc++) begin
            @(posedge clk);
            #1;
            check_flag("done", done, cyc == L);
            check_flag("busy", busy, cyc < L);
            // Old sums survive the clear cycle itself
            if (cyc == 1) begin
                check_matrix(prev_res);
            end
            if (cyc < N) begin
                #1;
                in_beat = make_beat(cyc);
            end else if (cyc == N) begin
                #1;
                in_valid = 1'b0;
                in_beat  = random_beat();
            end
        end
        check_matrix(exp_res);
        prev_res = exp_res;
    endtask

    ////////////////////////////////////////
    // Main sequence and watchdog
    ////////////////////////////////////////

    initial begin
        int gap;
        int mode;
        in_valid = 1'b0;
        in_beat  = '0;
        prev_res = '0;
        @(negedge rst);
        @(posedge clk);
        #1;
        // Out of reset, nothing running and every sum zero
        check_flag("done", done, 1'b0);
        check_flag("busy", busy, 1'b0);
        check_matrix(prev_res);
        for (int n = 0; n < NUM_JOBS; n++) begin
            mode = (n >= 2 && n <= 4) ? n - 1 : 0;
            // Every third job starts in the previous done cycle
            gap = (n % 3 == 1) ? 0 : 1 + int'(next_rand() >> 16) % N;
            repeat (gap) idle_cycle();
            run_job(mode);
        end
        repeat (2) idle_cycle();
        if (i_dut.u_seq.i_chk.fail_count != 0) begin
            $display("Sequencer assertions failed %0d times", i_dut.u_seq.i_chk.fail_count);
            $display("SOME TESTS FAILED");
            $fatal(1);
        end else begin
            $display("ALL TESTS PASSED");
            $finish;
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout: the run did not end within %0d clock cycles", WATCHDOG_CYCLES);
        $display("SOME TESTS FAILED");
        $fatal(1);
    end

endmodule

`default_nettype wire

// File: list.f
+incdir+design
design/mmu_pkg.sv
design/mac_pe.sv
design/skew_feeder.sv
design/systolic_grid.sv
design/job_sequencer.sv
design/mmu_top.sv
tests/mmu_clk_gen.sv
tests/mmu_chk.sv
tests/mmu_tb.sv

// File: run.sh
#!/bin/sh
# Build the matrix multiplier testbench with Verilator and run it.
# Passes only if the simulation output holds the pass message.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module mmu_tb -f list.f -o mmu_sim \
    && ./obj_dir/mmu_sim | tee /dev/stderr | grep -q "ALL TESTS PASSED" \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
